/* icache_if.sv */
`timescale 1ns/100ps
`default_nettype none

// stage-2 request and the registered lookup result
interface icache_lookup_if import icache_pkg::*; ();
    logic      s2_valid;
    tag_t      s2_tag;
    index_t    s2_index;
    word_sel_t s2_word;
    addr_t     s2_vaddr;
    logic      hit;
    way_t      hit_way;
    logic      bypass;
    line_t     bypass_line;

    modport req (
        output s2_valid, s2_tag, s2_index, s2_word, s2_vaddr
    );
    modport ways (
        input  s2_tag, s2_index, s2_word,
        output hit, hit_way, bypass, bypass_line
    );
    modport resp (
        input s2_valid, s2_tag, s2_index, s2_word, s2_vaddr,
        input hit, hit_way, bypass, bypass_line
    );
endinterface

// line refill into the arrays
interface icache_fill_if import icache_pkg::*; ();
    logic      fill_we;
    way_mask_t victim_way;
    line_t     fill_line;

    modport source (output fill_we, input victim_way);
    modport sink (input fill_we, victim_way, fill_line);
endinterface

`default_nettype wire

/* icache_pkg.sv */
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int NUM_WAYS       = 4;
    localparam int NUM_SETS       = 64;
    localparam int WORDS_PER_LINE = 8;
    localparam int OFFSET_W       = 5;
    localparam int INDEX_W        = 6;
    localparam int WORD_SEL_W     = 3;
    localparam int TAG_W          = 32 - INDEX_W - OFFSET_W;
    localparam int LINE_W         = WORDS_PER_LINE * 32;

    //////////////////////////////
    // address and data types
    typedef logic [31:0]           addr_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;
    typedef logic [31:0]           word_t;
    typedef logic [LINE_W-1:0]     line_t;

    // way number and one-hot way vector
    typedef logic [1:0]            way_t;
    typedef logic [NUM_WAYS-1:0]   way_mask_t;

    // one-hot mask to way number
    function automatic way_t way_encode(way_mask_t mask);
        way_t way;
        way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (mask[w]) begin
                way = way_t'(w);
            end
        end
        return way;
    endfunction

endpackage

`default_nettype wire

/* icache_plru.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_plru import icache_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  index_t    s2_index_i,
    input  logic      touch_i,
    input  way_t      touch_way_i,
    output way_mask_t victim_way_o
);

    // root picks pair {0,1} or {2,3}
    logic [NUM_SETS-1:0] root_q;
    // pair bits pick within {0,1} and {2,3}
    logic [NUM_SETS-1:0] low_q;
    logic [NUM_SETS-1:0] high_q;

    //////////////////////////////
    // victim of the stage 2 set
    always_comb begin
        victim_way_o = '0;
        if (!root_q[s2_index_i]) begin
            victim_way_o[{1'b0, low_q[s2_index_i]}] = 1'b1;
        end else begin
            victim_way_o[{1'b1, high_q[s2_index_i]}] = 1'b1;
        end
    end

    //////////////////////////////
    // update on every delivered request
    always_ff @(posedge clk) begin
        if (!rst) begin
            root_q <= '0;
            low_q  <= '0;
            high_q <= '0;
        end else if (touch_i) begin
            // point away from the touched way
            root_q[s2_index_i] <= ~touch_way_i[1];
            if (touch_way_i[1]) begin
                high_q[s2_index_i] <= ~touch_way_i[0];
            end else begin
                low_q[s2_index_i] <= ~touch_way_i[0];
            end
        end
    end

endmodule

`default_nettype wire

/* icache_req_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_req_stage import icache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   flush_i,
    input  logic   stall_i,
    input  logic   valid_i,
    input  addr_t  vaddr_i,
    input  addr_t  paddr_i,
    output index_t s1_index_o,
    output tag_t   s1_tag_o,
    output logic   s1_valid_o,
    icache_lookup_if.req lookup
);

    word_sel_t s1_word;

    //////////////////////////////
    // stage 1 address split
    // tag | index | word | byte
    assign s1_tag_o   = paddr_i[OFFSET_W+INDEX_W +: TAG_W];
    assign s1_index_o = paddr_i[OFFSET_W +: INDEX_W];
    assign s1_word    = paddr_i[OFFSET_W-1 -: WORD_SEL_W];

    // accepted this cycle
    assign s1_valid_o = valid_i && !stall_i;

    //////////////////////////////
    // stage 2 request register
    always_ff @(posedge clk) begin
        if (!rst || flush_i) begin
            lookup.s2_valid <= 1'b0;
        end else if (!stall_i) begin
            lookup.s2_valid <= valid_i;
        end
    end

    // fields only move when the pipe advances
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            lookup.s2_tag   <= s1_tag_o;
            lookup.s2_index <= s1_index_o;
            lookup.s2_word  <= s1_word;
            lookup.s2_vaddr <= vaddr_i;
        end
    end

    // a stalled miss keeps its address until the line is back
    a_s2_hold: assert property (@(posedge clk) disable iff (!rst)
        stall_i |=> $stable({lookup.s2_tag, lookup.s2_index, lookup.s2_word,
                             lookup.s2_vaddr}))
        else $error("stage 2 request changed under stall");

endmodule

`default_nettype wire

/* icache_resp.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_resp import icache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush_i,
    input  logic        ret_valid_i,
    input  line_t       ret_data_i,
    input  word_t [1:0] bank_words_i,
    icache_lookup_if.resp lookup,
    icache_fill_if.source fill,
    output logic        stall_o,
    output logic        touch_o,
    output way_t        touch_way_o,
    output logic        data_ok1_o,
    output logic        data_ok2_o,
    output word_t       rdata1_o,
    output word_t       rdata2_o,
    output addr_t       raddr_o,
    output logic        rd_req_o,
    output addr_t       rd_addr_o
);

    logic      miss;
    logic      ret_ok;
    logic      drop_q;
    line_t     src_line;
    word_sel_t next_word;

    //////////////////////////////
    // miss handling
    assign miss = lookup.s2_valid && !lookup.hit;

    // return belongs to the current miss unless a flushed one is still owed
    assign ret_ok = ret_valid_i && miss && !drop_q;

    // memory still owes a line for a miss dropped by flush
    always_ff @(posedge clk) begin
        if (!rst) begin
            drop_q <= 1'b0;
        end else if (drop_q) begin
            if (ret_valid_i) begin
                drop_q <= 1'b0;
            end
        end else if (flush_i && miss && !ret_valid_i) begin
            drop_q <= 1'b1;
        end
    end

    assign stall_o      = miss && !ret_ok;
    assign rd_req_o     = miss && !drop_q && !ret_valid_i;
    assign rd_addr_o    = {lookup.s2_tag, lookup.s2_index, {OFFSET_W{1'b0}}};
    assign fill.fill_we = ret_ok;

    //////////////////////////////
    // output words
    assign data_ok1_o = (lookup.s2_valid && lookup.hit) || ret_ok;
    // no second word past the end of the line
    assign data_ok2_o = data_ok1_o && (lookup.s2_word != '1);
    assign raddr_o    = lookup.s2_vaddr;

    assign next_word = lookup.s2_word + 1'b1;
    assign src_line  = lookup.bypass ? lookup.bypass_line : ret_data_i;

    always_comb begin
        if (lookup.hit && !lookup.bypass) begin
            rdata1_o = bank_words_i[0];
            rdata2_o = bank_words_i[1];
        end else begin
            rdata1_o = src_line[{lookup.s2_word, 5'd0} +: 32];
            rdata2_o = src_line[{next_word, 5'd0} +: 32];
        end
    end

    // replacement update
    assign touch_o     = data_ok1_o;
    assign touch_way_o = lookup.hit ? lookup.hit_way : way_encode(fill.victim_way);

    a_req_stall: assert property (@(posedge clk) disable iff (!rst)
        rd_req_o |-> stall_o)
        else $error("read request without stall");

endmodule

`default_nettype wire

/* icache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_top import icache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  flush_i,
    input  logic  valid_i,
    input  addr_t vaddr_i,
    input  addr_t paddr_i,
    output logic  stall_o,
    output logic  data_ok1_o,
    output logic  data_ok2_o,
    output word_t rdata1_o,
    output word_t rdata2_o,
    output addr_t raddr_o,
    output logic  rd_req_o,
    output addr_t rd_addr_o,
    input  logic  ret_valid_i,
    input  line_t ret_data_i
);

    index_t      s1_index;
    tag_t        s1_tag;
    logic        s1_valid;
    logic        touch;
    way_t        touch_way;
    word_t [1:0] bank_words;

    icache_lookup_if lookup ();
    icache_fill_if   fill ();

    // refill data comes straight from memory
    assign fill.fill_line = ret_data_i;

    //////////////////////////////
    icache_req_stage u_req (
        .clk        (clk),
        .rst        (rst),
        .flush_i    (flush_i),
        .stall_i    (stall_o),
        .valid_i    (valid_i),
        .vaddr_i    (vaddr_i),
        .paddr_i    (paddr_i),
        .s1_index_o (s1_index),
        .s1_tag_o   (s1_tag),
        .s1_valid_o (s1_valid),
        .lookup     (lookup.req)
    );

    icache_ways u_ways (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush_i),
        .stall_i      (stall_o),
        .s1_index_i   (s1_index),
        .s1_tag_i     (s1_tag),
        .s1_valid_i   (s1_valid),
        .lookup       (lookup.ways),
        .fill         (fill.sink),
        .bank_words_o (bank_words)
    );

    icache_plru u_plru (
        .clk          (clk),
        .rst          (rst),
        .s2_index_i   (lookup.s2_index),
        .touch_i      (touch),
        .touch_way_i  (touch_way),
        .victim_way_o (fill.victim_way)
    );

    icache_resp u_resp (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush_i),
        .ret_valid_i  (ret_valid_i),
        .ret_data_i   (ret_data_i),
        .bank_words_i (bank_words),
        .lookup       (lookup.resp),
        .fill         (fill.source),
        .stall_o      (stall_o),
        .touch_o      (touch),
        .touch_way_o  (touch_way),
        .data_ok1_o   (data_ok1_o),
        .data_ok2_o   (data_ok2_o),
        .rdata1_o     (rdata1_o),
        .rdata2_o     (rdata2_o),
        .raddr_o      (raddr_o),
        .rd_req_o     (rd_req_o),
        .rd_addr_o    (rd_addr_o)
    );

endmodule

`default_nettype wire

/* icache_trace.txt */
# kind (R request, F flush), physical address in hex, outcome (H hit, M miss, - none)
# set 0 line first, then five tags in set 1, then a flushed miss in set 2
R 00001004 M
R 00001008 H
R 0000100c H
R 00001010 H
R 0000101c H
R 00001000 H
R 00010020 M
R 00020020 M
R 00030020 M
R 00040020 M
R 00010024 H
R 00050020 M
R 00020020 M
R 00040020 H
R 00050024 H
R 00030020 M
R 00080044 M
F 00000000 -
R 00080048 M
R 0008004c H
R 0000101c H
R 00010020 M

/* icache_ways.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_ways import icache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush_i,
    input  logic        stall_i,
    input  index_t      s1_index_i,
    input  tag_t        s1_tag_i,
    input  logic        s1_valid_i,
    icache_lookup_if.ways lookup,
    icache_fill_if.sink fill,
    output word_t [1:0] bank_words_o
);

    // tag store and valid bits, per way and set
    tag_t                              tag_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;

    // one bank per word of the line
    word_t data_mem [NUM_WAYS][WORDS_PER_LINE][NUM_SETS];
    word_t bank_q   [NUM_WAYS][WORDS_PER_LINE];

    index_t    rd_index;
    logic      same_set;
    logic      collide;
    way_mask_t way_hit;
    word_sel_t next_word;

    //////////////////////////////
    // tag compare
    assign same_set = fill.fill_we && (s1_index_i == lookup.s2_index);

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (same_set && fill.victim_way[w]) begin
                // array still holds the old line, use the written tag
                way_hit[w] = (s1_tag_i == lookup.s2_tag);
            end else begin
                way_hit[w] = valid_q[w][s1_index_i]
                             && (tag_mem[w][s1_index_i] == s1_tag_i);
            end
        end
    end

    // stage 1 hits the line being refilled
    assign collide = same_set && |(way_hit & fill.victim_way);

    always_ff @(posedge clk) begin
        if (!rst || flush_i) begin
            lookup.hit    <= 1'b0;
            lookup.bypass <= 1'b0;
        end else if (!stall_i) begin
            lookup.hit    <= s1_valid_i && |way_hit;
            lookup.bypass <= s1_valid_i && collide;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            lookup.hit_way <= way_encode(way_hit);
        end
        if (collide) begin
            lookup.bypass_line <= fill.fill_line;
        end
    end

    //////////////////////////////
    // refill write of tag and valid
    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_q <= '0;
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (fill.fill_we && fill.victim_way[w]) begin
                    valid_q[w][lookup.s2_index] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (fill.fill_we && fill.victim_way[w]) begin
                tag_mem[w][lookup.s2_index] <= lookup.s2_tag;
            end
        end
    end

    //////////////////////////////
    // data banks, hold the stage 2 set while stalled
    assign rd_index = stall_i ? lookup.s2_index : s1_index_i;

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            for (int b = 0; b < WORDS_PER_LINE; b++) begin
                if (fill.fill_we && fill.victim_way[w]) begin
                    data_mem[w][b][lookup.s2_index] <= fill.fill_line[b*32 +: 32];
                end
                bank_q[w][b] <= data_mem[w][b][rd_index];
            end
        end
    end

    // word pair of the hit way
    assign next_word       = lookup.s2_word + 1'b1;
    assign bank_words_o[0] = bank_q[lookup.hit_way][lookup.s2_word];
    assign bank_words_o[1] = bank_q[lookup.hit_way][next_word];

    // a tag lives in one way only, refill bypass included
    a_one_way: assert property (@(posedge clk) disable iff (!rst)
        s1_valid_i |-> $onehot0(way_hit))
        else $error("more than one way hits");

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_icache \
    -f tb.f -o sim_icache > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_icache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" sim.log; then
    exit 0
fi
exit 1

/* tb.f */
icache_pkg.sv
icache_if.sv
icache_req_stage.sv
icache_ways.sv
icache_plru.sv
icache_resp.sv
icache_top.sv
tb_icache.sv

/* tb_icache.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_icache import icache_pkg::*; ();

    logic  clk;
    logic  rst;
    logic  flush_i;
    logic  valid_i;
    addr_t vaddr_i;
    addr_t paddr_i;
    logic  stall_o;
    logic  data_ok1_o;
    logic  data_ok2_o;
    word_t rdata1_o;
    word_t rdata2_o;
    addr_t raddr_o;
    logic  rd_req_o;
    addr_t rd_addr_o;
    logic  ret_valid_i;
    line_t ret_data_i;

    // one entry per trace record
    logic [7:0] tr_kind [$];
    addr_t      tr_addr [$];
    logic [7:0] tr_exp  [$];

    logic [31:0] rng_state = 32'h148b_aeaf;
    int          errors = 0;

    icache_top dut0 (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // memory image, each word holds the inverse of its byte address
    function automatic line_t make_line(addr_t line_addr);
        line_t line;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            line[i*32 +: 32] = ~(line_addr + 32'(i * 4));
        end
        return line;
    endfunction

    task automatic report_value(string name, logic [31:0] got, logic [31:0] exp);
        $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic report_fault(string what);
        $display("error at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic read_trace();
        int         fd;
        int         n;
        string      text;
        logic [7:0] kind;
        logic [7:0] exp;
        addr_t      addr;
        fd = $fopen("icache_trace.txt", "r");
        if (fd == 0) begin
            report_fault("cannot open icache_trace.txt");
            return;
        end
        while ($fgets(text, fd) != 0) begin
            n = $sscanf(text, "%c %h %c", kind, addr, exp);
            // comment lines stop after the first column
            if (n == 3 && kind != "#") begin
                tr_kind.push_back(kind);
                tr_addr.push_back(addr);
                tr_exp.push_back(exp);
            end
        end
        $fclose(fd);
    endtask

    // word pair rule: first word, then the next one unless word 7
    task automatic check_words(addr_t addr);
        addr_t word_addr;
        word_addr = {addr[31:2], 2'b00};
        if (rdata1_o !== ~word_addr)
            report_value("rdata1_o", rdata1_o, ~word_addr);
        if (raddr_o !== addr)
            report_value("raddr_o", raddr_o, addr);
        if (addr[OFFSET_W-1:2] == 3'd7) begin
            if (data_ok2_o !== 1'b0)
                report_value("data_ok2_o", 32'(data_ok2_o), 32'd0);
        end else begin
            if (data_ok2_o !== 1'b1)
                report_value("data_ok2_o", 32'(data_ok2_o), 32'd1);
            if (rdata2_o !== ~(word_addr + 32'd4))
                report_value("rdata2_o", rdata2_o, ~(word_addr + 32'd4));
        end
    endtask

    initial begin
        // request held in stage 2, as the checker sees it
        logic       s2_busy;
        addr_t      s2_addr;
        logic [7:0] s2_exp;
        logic [7:0] seen;
        logic       s2_req_seen;
        int         s2_age;
        int         s2_id;
        int         s2_errors;
        // memory model
        logic       mem_busy;
        addr_t      mem_addr;
        int         mem_wait;
        // request that the line in flight was fetched for
        int         mem_owner;
        logic       flush_next;
        addr_t      exp_addr;
        string      note;
        int         ptr;
        int         cycle;
        int         limit;
        int         tests;
        int         failed;
        int         last_hit;
        int         pairs;

        clk         = 1'b0;
        rst         = 1'b0;
        flush_i     = 1'b0;
        valid_i     = 1'b0;
        vaddr_i     = '0;
        paddr_i     = '0;
        ret_valid_i = 1'b0;
        ret_data_i  = '0;
        s2_busy     = 1'b0;
        s2_addr     = '0;
        s2_exp      = "-";
        seen        = "-";
        s2_req_seen = 1'b0;
        s2_age      = 0;
        s2_id       = 0;
        s2_errors   = 0;
        mem_busy    = 1'b0;
        mem_addr    = '0;
        mem_wait    = 0;
        mem_owner   = -1;
        flush_next  = 1'b0;
        ptr         = 0;
        cycle       = 0;
        tests       = 0;
        failed      = 0;
        last_hit    = -10;
        pairs       = 0;

        read_trace();
        limit = tr_kind.size() * 10 + 50;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        while (cycle < limit && (ptr < tr_kind.size() || s2_busy || mem_busy || flush_next)) begin
            @(negedge clk);
            cycle++;

            //////////////////////////////
            // memory answers a few cycles after rd_req_o
            ret_valid_i = 1'b0;
            if (mem_busy) begin
                mem_wait--;
                if (mem_wait == 0) begin
                    ret_valid_i = 1'b1;
                    ret_data_i  = make_line(mem_addr);
                    mem_busy    = 1'b0;
                end
            end

            // next request, held until the cache takes it
            flush_i = flush_next;
            valid_i = 1'b0;
            if (!flush_next && ptr < tr_kind.size()) begin
                if (tr_kind[ptr] == "F") begin
                    flush_i = 1'b1;
                    ptr++;
                end else begin
                    valid_i = 1'b1;
                    paddr_i = tr_addr[ptr];
                    vaddr_i = tr_addr[ptr];
                end
            end
            flush_next = 1'b0;
            #1;

            //////////////////////////////
            // response of the stage 2 request
            if (s2_busy) begin
                if (s2_age == 0)
                    seen = data_ok1_o ? "H" : "M";
                if (rd_req_o) begin
                    s2_req_seen = 1'b1;
                    exp_addr = {s2_addr[31:OFFSET_W], {OFFSET_W{1'b0}}};
                    if (rd_addr_o !== exp_addr)
                        report_value("rd_addr_o", rd_addr_o, exp_addr);
                    if (seen == "H")
                        report_fault("rd_req_o raised on a hit");
                end
                if (flush_i || data_ok1_o || !stall_o) begin
                    note = "done";
                    if (flush_i) begin
                        note = "flushed";
                        if (data_ok1_o)
                            report_fault("data_ok1_o for a flushed request");
                    end else if (!data_ok1_o) begin
                        report_fault("stall_o dropped before data_ok1_o");
                    end else begin
                        check_words(s2_addr);
                        if (seen == "M" && !s2_req_seen)
                            report_fault("miss served without rd_req_o");
                        if (seen == "M" && mem_owner != s2_id)
                            report_fault("miss served with a line fetched for another request");
                    end
                    if (seen != s2_exp) begin
                        $display("ERR %0t outcome got %c expected %c", $time, seen, s2_exp);
                        errors++;
                    end
                    if (seen == "H" && data_ok1_o) begin
                        if (last_hit == cycle - 1)
                            pairs++;
                        last_hit = cycle;
                    end
                    tests++;
                    if (errors != s2_errors)
                        failed++;
                    $display("request %0d addr %h %c %s: %s", s2_id, s2_addr, seen, note,
                             (errors == s2_errors) ? "ok" : "mismatch");
                    s2_busy = 1'b0;
                end
                s2_age++;
            end else if (stall_o || rd_req_o || data_ok1_o || data_ok2_o) begin
                report_fault("output active with no request in stage 2");
            end

            // acceptance at the coming edge
            if (valid_i && !stall_o) begin
                s2_busy     = 1'b1;
                s2_addr     = tr_addr[ptr];
                s2_exp      = tr_exp[ptr];
                s2_id       = ptr;
                s2_age      = 0;
                s2_req_seen = 1'b0;
                s2_errors   = errors;
                ptr++;
                if (ptr < tr_kind.size() && tr_kind[ptr] == "F") begin
                    flush_next = 1'b1;
                    ptr++;
                end
            end
            if (rd_req_o && !mem_busy) begin
                rng_state = xorshift32(rng_state);
                mem_busy  = 1'b1;
                mem_addr  = rd_addr_o;
                mem_owner = s2_id;
                mem_wait  = int'(rng_state[1:0]) + 1;
            end
        end

        if (ptr < tr_kind.size() || s2_busy || mem_busy || flush_next)
            report_fault($sformatf("run stopped after %0d cycles with work left", cycle));
        if (tests == 0)
            report_fault("no requests read from the trace");
        if (pairs == 0)
            report_fault("no back-to-back hits seen");
        $display("requests %0d failed %0d errors %0d back-to-back hits %0d",
                 tests, failed, errors, pairs);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
